//--- rx_meta_front_params.svh
`ifndef RX_META_FRONT_PARAMS_SVH
`define RX_META_FRONT_PARAMS_SVH

// Packet queues and queue-manager lanes.
`define FLOW_IDX_WIDTH 6
`define MAX_NB_FLOWS 64
`define NB_PKT_QMS 4
`define PKT_QM_ID_WIDTH 2
`define PKT_SIZE_WIDTH 16

// Host address and write data layout.
`define MMIO_ADDR_WIDTH 20
`define MMIO_PAGE_LSB 12
`define MMIO_PAGE_WIDTH 8
`define CTRL_PAGE 255
`define MMIO_DATA_WIDTH 64
`define MMIO_BYTE_WIDTH 3
`define REG_BYTES 4
`define NB_CONTROL_REGS 4
`define CTRL_IDX_WIDTH 2

// Queue depths and thresholds.
`define HEAD_UPD_QUEUE_LEN 16
`define HEAD_UPD_SLACK 4
`define IN_QUEUE_DEPTH 8
`define IN_QUEUE_ALMOST_FULL 4

`endif

//--- rx_meta_pkg.sv
`include "rx_meta_front_params.svh"

package rx_meta_pkg;

// Metadata as delivered by the receive buffer.
typedef struct packed {
    logic [`FLOW_IDX_WIDTH-1:0] queue_id;
    logic [`PKT_SIZE_WIDTH-1:0] size;
} pkt_meta_t;

// Record handed to a queue-manager lane.
typedef struct packed {
    logic [`FLOW_IDX_WIDTH-1:0] queue_id;
    logic [`PKT_SIZE_WIDTH-1:0] size;
    logic                       descriptor_only;
} qm_meta_t;

// The same host address seen as a queue page or as the control page.
typedef union packed {
    struct packed {
        logic [`MMIO_PAGE_WIDTH-1:0] page;
        logic [`MMIO_PAGE_LSB-1:0]   reg_off;
    } queue;
    struct packed {
        logic [`MMIO_PAGE_WIDTH-1:0]                                page;
        logic [`MMIO_PAGE_LSB-`CTRL_IDX_WIDTH-`MMIO_BYTE_WIDTH-1:0] spare;
        logic [`CTRL_IDX_WIDTH-1:0]                                 reg_idx;
        logic [`MMIO_BYTE_WIDTH-1:0]                                byte_off;
    } ctrl;
} mmio_addr_u;

typedef struct packed {
    logic                           wr;
    mmio_addr_u                     addr;
    logic [`MMIO_DATA_WIDTH-1:0]    data;
    logic [`MMIO_DATA_WIDTH/8-1:0]  byteen;
} mmio_wr_t;

endpackage

//--- sync_fifo.sv
`timescale 1ns/1ns

module sync_fifo #(
    parameter int WIDTH = 8,
    parameter int DEPTH = 16
) (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic [WIDTH-1:0]           in_data,
    input  logic                       in_valid,
    output logic                       in_ready,
    output logic [WIDTH-1:0]           out_data,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [$clog2(DEPTH+1)-1:0] occup
);

localparam int AW = $clog2(DEPTH);
localparam int OW = $clog2(DEPTH+1);

logic [WIDTH-1:0] mem [DEPTH];
logic [AW-1:0]    wr_ptr;
logic [AW-1:0]    rd_ptr;
logic             push;
logic             pop;

assign in_ready  = (occup != OW'(DEPTH));
assign out_valid = (occup != '0);
// Head entry is visible without a read request.
assign out_data  = mem[rd_ptr];

assign push = in_valid & in_ready;
assign pop  = out_valid & out_ready;

always_ff @(posedge pcie_clk) begin
    if (push) begin
        mem[wr_ptr] <= in_data;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        wr_ptr <= '0;
        rd_ptr <= '0;
        occup  <= '0;
    end else begin
        if (push) begin
            wr_ptr <= (wr_ptr == AW'(DEPTH-1)) ? '0 : wr_ptr + 1'b1;
        end
        if (pop) begin
            rd_ptr <= (rd_ptr == AW'(DEPTH-1)) ? '0 : rd_ptr + 1'b1;
        end
        if (push && !pop) begin
            occup <= occup + 1'b1;
        end else if (pop && !push) begin
            occup <= occup - 1'b1;
        end
    end
end

endmodule

//--- mmio_ctrl_decoder.sv
`timescale 1ns/1ns
`include "rx_meta_front_params.svh"

module mmio_ctrl_decoder (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  rx_meta_pkg::mmio_wr_t      mmio_wr,
    output logic                       disable_pcie,
    output logic                       eth_port_nb,
    output logic                       sw_reset,
    output logic                       head_upd,
    output logic [`FLOW_IDX_WIDTH-1:0] head_upd_flow
);

logic [`REG_BYTES*8-1:0] control_regs [`NB_CONTROL_REGS];
logic                    ctrl_wr;
logic                    head_wr;
logic                    sw_reset_meta;

// Control registers take only full low-word writes.
assign ctrl_wr = mmio_wr.wr
    && (mmio_wr.addr.ctrl.page == `CTRL_PAGE)
    && (&mmio_wr.byteen[`REG_BYTES-1:0]);

// Head pointer lives in the upper word of a queue page.
assign head_wr = mmio_wr.wr
    && (mmio_wr.addr.queue.page < `MAX_NB_FLOWS)
    && (&mmio_wr.byteen[2*`REG_BYTES-1:`REG_BYTES]);

assign disable_pcie = control_regs[0][0];
assign eth_port_nb  = control_regs[2][31];

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        for (int i = 0; i < `NB_CONTROL_REGS; i++) begin
            control_regs[i] <= '0;
        end
    end else if (ctrl_wr) begin
        control_regs[mmio_wr.addr.ctrl.reg_idx] <= mmio_wr.data[`REG_BYTES*8-1:0];
    end
end

// Software reset is set and cleared by the host, bit 27 of register 0.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        sw_reset_meta <= 1'b0;
        sw_reset      <= 1'b0;
    end else begin
        sw_reset_meta <= control_regs[0][27];
        sw_reset      <= sw_reset_meta;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        head_upd <= 1'b0;
    end else begin
        head_upd <= head_wr;
    end
end

always_ff @(posedge pcie_clk) begin
    head_upd_flow <= mmio_wr.addr.queue.page[`FLOW_IDX_WIDTH-1:0];
end

endmodule

//--- head_upd_tracker.sv
`timescale 1ns/1ns
`include "rx_meta_front_params.svh"

module head_upd_tracker (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic                       head_upd,
    input  logic [`FLOW_IDX_WIDTH-1:0] head_upd_flow,
    output logic [`FLOW_IDX_WIDTH-1:0] out_flow,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [31:0]                rx_ignored_head_cnt
);

logic [$clog2(`HEAD_UPD_QUEUE_LEN+1)-1:0] queue_occup;
logic                                     almost_full;
logic                                     push_ok;

// The slack keeps the queue from ever reaching full.
assign almost_full = queue_occup > (`HEAD_UPD_QUEUE_LEN - `HEAD_UPD_SLACK);
assign push_ok     = !almost_full;

sync_fifo #(
    .WIDTH (`FLOW_IDX_WIDTH),
    .DEPTH (`HEAD_UPD_QUEUE_LEN)
) head_upd_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (head_upd_flow),
    .in_valid     (head_upd & push_ok),
    .in_ready     (),
    .out_data     (out_flow),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .occup        (queue_occup)
);

// Updates that find the queue nearly full are lost, only counted here.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        rx_ignored_head_cnt <= '0;
    end else if (head_upd && !push_ok) begin
        rx_ignored_head_cnt <= rx_ignored_head_cnt + 1'b1;
    end
end

endmodule

//--- meta_merge_stage.sv
`timescale 1ns/1ns
`include "rx_meta_front_params.svh"

module meta_merge_stage (
    input  logic                       pcie_clk,
    input  logic                       pcie_reset_n,
    input  logic                       sw_reset,
    input  logic [`FLOW_IDX_WIDTH-1:0] head_flow,
    input  logic                       head_valid,
    output logic                       head_ready,
    input  rx_meta_pkg::pkt_meta_t     pkt_meta,
    input  logic                       pkt_meta_valid,
    output logic                       pkt_meta_ready,
    output rx_meta_pkg::qm_meta_t      out_meta,
    output logic                       out_valid,
    input  logic                       out_ready,
    output logic [31:0]                rx_pkt_head_upd_cnt
);

logic [$clog2(`IN_QUEUE_DEPTH+1)-1:0] in_queue_occup;
logic                                 in_queue_almost_full;
rx_meta_pkg::qm_meta_t                in_queue_in_data;
logic                                 in_queue_in_valid;
logic                                 merge_en;

assign in_queue_almost_full = in_queue_occup > `IN_QUEUE_ALMOST_FULL;

// Head updates win. Metadata only moves when no head update waits.
assign head_ready     = merge_en && !in_queue_almost_full;
assign pkt_meta_ready = merge_en && !in_queue_almost_full && !head_valid;

// Opens the merge one cycle after reset is released.
always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n) begin
        merge_en          <= 1'b0;
        in_queue_in_valid <= 1'b0;
    end else begin
        merge_en          <= 1'b1;
        in_queue_in_valid <= (head_valid & head_ready) | (pkt_meta_valid & pkt_meta_ready);
    end
end

always_ff @(posedge pcie_clk) begin
    if (head_valid & head_ready) begin
        in_queue_in_data.queue_id        <= head_flow;
        in_queue_in_data.size            <= '0;
        in_queue_in_data.descriptor_only <= 1'b1;
    end else begin
        in_queue_in_data.queue_id        <= pkt_meta.queue_id;
        in_queue_in_data.size            <= pkt_meta.size;
        in_queue_in_data.descriptor_only <= 1'b0;
    end
end

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n || sw_reset) begin
        rx_pkt_head_upd_cnt <= '0;
    end else if (head_valid & head_ready) begin
        rx_pkt_head_upd_cnt <= rx_pkt_head_upd_cnt + 1'b1;
    end
end

sync_fifo #(
    .WIDTH ($bits(rx_meta_pkg::qm_meta_t)),
    .DEPTH (`IN_QUEUE_DEPTH)
) in_queue (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .in_data      (in_queue_in_data),
    .in_valid     (in_queue_in_valid),
    .in_ready     (),
    .out_data     (out_meta),
    .out_valid    (out_valid),
    .out_ready    (out_ready),
    .occup        (in_queue_occup)
);

endmodule

//--- qm_dispatcher.sv
`timescale 1ns/1ns
`include "rx_meta_front_params.svh"

module qm_dispatcher (
    input  logic                   pcie_clk,
    input  logic                   pcie_reset_n,
    input  logic                   sw_reset,
    input  rx_meta_pkg::qm_meta_t  in_meta,
    input  logic                   in_valid,
    output logic                   in_ready,
    output rx_meta_pkg::qm_meta_t  qm_meta,
    output logic [`NB_PKT_QMS-1:0] qm_valid,
    input  logic [`NB_PKT_QMS-1:0] qm_ready
);

rx_meta_pkg::qm_meta_t        held_meta;
logic                         held_valid;
logic [`PKT_QM_ID_WIDTH-1:0]  lane;
logic                         send;

// Lane comes from the low queue id bits.
assign lane    = held_meta.queue_id[`PKT_QM_ID_WIDTH-1:0];
assign qm_meta = held_meta;

always_comb begin
    qm_valid = '0;
    send     = held_valid && qm_ready[lane];
    qm_valid[lane] = send;
end

// Refill when empty or while the held record is leaving.
assign in_ready = !held_valid || send;

always_ff @(posedge pcie_clk) begin
    if (!pcie_reset_n || sw_reset) begin
        held_valid <= 1'b0;
    end else if (in_valid && in_ready) begin
        held_valid <= 1'b1;
    end else if (send) begin
        held_valid <= 1'b0;
    end
end

always_ff @(posedge pcie_clk) begin
    if (in_valid && in_ready) begin
        held_meta <= in_meta;
    end
end

endmodule

//--- rx_meta_front.sv
`timescale 1ns/1ns
`include "rx_meta_front_params.svh"

module rx_meta_front (
    input  logic                   pcie_clk,
    input  logic                   pcie_reset_n,
    input  rx_meta_pkg::mmio_wr_t  mmio_wr,
    input  rx_meta_pkg::pkt_meta_t rx_meta,
    input  logic                   rx_meta_valid,
    output logic                   rx_meta_ready,
    output rx_meta_pkg::qm_meta_t  qm_meta,
    output logic [`NB_PKT_QMS-1:0] qm_valid,
    input  logic [`NB_PKT_QMS-1:0] qm_ready,
    output logic                   disable_pcie,
    output logic                   eth_port_nb,
    output logic                   sw_reset,
    output logic [31:0]            rx_ignored_head_cnt,
    output logic [31:0]            rx_pkt_head_upd_cnt
);

logic                       head_upd;
logic [`FLOW_IDX_WIDTH-1:0] head_upd_flow;
logic [`FLOW_IDX_WIDTH-1:0] head_flow;
logic                       head_valid;
logic                       head_ready;
rx_meta_pkg::qm_meta_t      merged_meta;
logic                       merged_valid;
logic                       merged_ready;

mmio_ctrl_decoder mmio_ctrl_decoder_inst (
    .pcie_clk      (pcie_clk),
    .pcie_reset_n  (pcie_reset_n),
    .mmio_wr       (mmio_wr),
    .disable_pcie  (disable_pcie),
    .eth_port_nb   (eth_port_nb),
    .sw_reset      (sw_reset),
    .head_upd      (head_upd),
    .head_upd_flow (head_upd_flow)
);

head_upd_tracker head_upd_tracker_inst (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .head_upd            (head_upd),
    .head_upd_flow       (head_upd_flow),
    .out_flow            (head_flow),
    .out_valid           (head_valid),
    .out_ready           (head_ready),
    .rx_ignored_head_cnt (rx_ignored_head_cnt)
);

meta_merge_stage meta_merge_stage_inst (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .sw_reset            (sw_reset),
    .head_flow           (head_flow),
    .head_valid          (head_valid),
    .head_ready          (head_ready),
    .pkt_meta            (rx_meta),
    .pkt_meta_valid      (rx_meta_valid),
    .pkt_meta_ready      (rx_meta_ready),
    .out_meta            (merged_meta),
    .out_valid           (merged_valid),
    .out_ready           (merged_ready),
    .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt)
);

qm_dispatcher qm_dispatcher_inst (
    .pcie_clk     (pcie_clk),
    .pcie_reset_n (pcie_reset_n),
    .sw_reset     (sw_reset),
    .in_meta      (merged_meta),
    .in_valid     (merged_valid),
    .in_ready     (merged_ready),
    .qm_meta      (qm_meta),
    .qm_valid     (qm_valid),
    .qm_ready     (qm_ready)
);

endmodule

//--- tb_rx_meta_front.sv
`timescale 1ns/1ns
`include "rx_meta_front_params.svh"

module tb_rx_meta_front;

localparam int SEED = 32'hb9c15daa;
// About 150 cycles of packets, 150 of head updates and 200 of overload, with wide margin.
localparam int MAX_CYCLES = 4000;
localparam int NB_PKTS = 60;
localparam int NB_HEADS = 20;
localparam int NB_BURST = 40;

logic                          pcie_clk;
logic                          pcie_reset_n;
rx_meta_pkg::mmio_wr_t         mmio_wr;
rx_meta_pkg::pkt_meta_t        rx_meta;
logic                          rx_meta_valid;
logic                          rx_meta_ready;
rx_meta_pkg::qm_meta_t         qm_meta;
logic [`NB_PKT_QMS-1:0]        qm_valid;
logic [`NB_PKT_QMS-1:0]        qm_ready;
logic                          disable_pcie;
logic                          eth_port_nb;
logic                          sw_reset;
logic [31:0]                   rx_ignored_head_cnt;
logic [31:0]                   rx_pkt_head_upd_cnt;

rx_meta_pkg::qm_meta_t exp_pkt_q [`NB_PKT_QMS][$];
rx_meta_pkg::qm_meta_t exp_head_q [`NB_PKT_QMS][$];
int                    mismatch_cnt = 0;
int                    fail_cnt = 0;
int                    cycle_cnt = 0;
int                    head_seen = 0;
int                    ready_mode = 0;
bit                    check_heads = 1'b1;

rx_meta_front rx_meta_front_inst (
    .pcie_clk            (pcie_clk),
    .pcie_reset_n        (pcie_reset_n),
    .mmio_wr             (mmio_wr),
    .rx_meta             (rx_meta),
    .rx_meta_valid       (rx_meta_valid),
    .rx_meta_ready       (rx_meta_ready),
    .qm_meta             (qm_meta),
    .qm_valid            (qm_valid),
    .qm_ready            (qm_ready),
    .disable_pcie        (disable_pcie),
    .eth_port_nb         (eth_port_nb),
    .sw_reset            (sw_reset),
    .rx_ignored_head_cnt (rx_ignored_head_cnt),
    .rx_pkt_head_upd_cnt (rx_pkt_head_upd_cnt)
);

// Reference model of the record a lane should see for one input event.
function automatic rx_meta_pkg::qm_meta_t expected_record(input logic is_head,
        input logic [`FLOW_IDX_WIDTH-1:0] qid, input logic [`PKT_SIZE_WIDTH-1:0] size);
    rx_meta_pkg::qm_meta_t rec;
    rec.queue_id        = qid;
    rec.size            = is_head ? '0 : size;
    rec.descriptor_only = is_head;
    return rec;
endfunction

function automatic int expected_lane(input logic [`FLOW_IDX_WIDTH-1:0] qid);
    return int'(qid) % `NB_PKT_QMS;
endfunction

function automatic int pending_count();
    int total;
    total = 0;
    for (int i = 0; i < `NB_PKT_QMS; i++) begin
        total += exp_pkt_q[i].size() + exp_head_q[i].size();
    end
    return total;
endfunction

task automatic compare_value(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp == act) else begin
        $display("MISMATCH %s: expected %0h, actual %0h", name, exp, act);
        mismatch_cnt++;
    end
endtask

task automatic next_cycle();
    @(posedge pcie_clk);
    #2;
endtask

task automatic write_ctrl(input int idx, input logic [31:0] value, input logic [7:0] be);
    rx_meta_pkg::mmio_wr_t w;
    w                   = '0;
    w.wr                = 1'b1;
    w.addr.ctrl.page    = 8'(`CTRL_PAGE);
    w.addr.ctrl.reg_idx = 2'(idx);
    w.data              = {32'h0, value};
    w.byteen            = be;
    mmio_wr             = w;
    next_cycle();
    mmio_wr.wr = 1'b0;
endtask

// Head pointer goes in the upper word of a queue page.
task automatic write_head(input logic [7:0] page, input logic [7:0] be);
    rx_meta_pkg::mmio_wr_t w;
    w                 = '0;
    w.wr              = 1'b1;
    w.addr.queue.page = page;
    w.data            = {$urandom, 32'h0};
    w.byteen          = be;
    mmio_wr           = w;
    next_cycle();
    mmio_wr.wr = 1'b0;
endtask

task automatic send_pkt(input logic [`FLOW_IDX_WIDTH-1:0] qid,
        input logic [`PKT_SIZE_WIDTH-1:0] size);
    logic done;
    done             = 1'b0;
    rx_meta.queue_id = qid;
    rx_meta.size     = size;
    rx_meta_valid    = 1'b1;
    while (!done) begin
        @(negedge pcie_clk);
        if (rx_meta_ready) begin
            exp_pkt_q[expected_lane(qid)].push_back(expected_record(1'b0, qid, size));
            done = 1'b1;
        end
        next_cycle();
    end
    rx_meta_valid = 1'b0;
endtask

task automatic wait_drain();
    while (pending_count() != 0) begin
        next_cycle();
    end
    repeat (4) next_cycle();
endtask

initial begin
    pcie_clk = 1'b0;
    forever #20 pcie_clk = ~pcie_clk;
end

// Lane ready pattern, changed just after each rising edge.
initial begin
    forever begin
        next_cycle();
        case (ready_mode)
            0:       qm_ready = '0;
            1:       qm_ready = `NB_PKT_QMS'($urandom);
            default: qm_ready = `NB_PKT_QMS'($urandom | $urandom);
        endcase
    end
end

// Checks every lane transfer against the expected queues.
initial begin
    int                    lane;
    rx_meta_pkg::qm_meta_t exp_rec;
    forever begin
        @(negedge pcie_clk);
        if (pcie_reset_n && qm_valid != '0) begin
            assert ($countones(qm_valid) == 1) else begin
                $display("ERROR: several lanes valid at once, qm_valid=%b", qm_valid);
                fail_cnt++;
            end
            lane = 0;
            for (int i = 0; i < `NB_PKT_QMS; i++) begin
                if (qm_valid[i]) lane = i;
            end
            compare_value("lane select", expected_lane(qm_meta.queue_id), lane);
            if (qm_meta.descriptor_only) begin
                head_seen++;
                if (check_heads) begin
                    assert (exp_head_q[lane].size() != 0) else begin
                        $display("ERROR: unexpected head update record on lane %0d", lane);
                        fail_cnt++;
                    end
                    if (exp_head_q[lane].size() != 0) begin
                        exp_rec = exp_head_q[lane].pop_front();
                        compare_value("head update record", exp_rec, qm_meta);
                    end
                end
            end else begin
                assert (exp_pkt_q[lane].size() != 0) else begin
                    $display("ERROR: unexpected packet record on lane %0d", lane);
                    fail_cnt++;
                end
                if (exp_pkt_q[lane].size() != 0) begin
                    exp_rec = exp_pkt_q[lane].pop_front();
                    compare_value("packet record", exp_rec, qm_meta);
                end
            end
        end
    end
end

initial begin
    while (cycle_cnt < MAX_CYCLES) begin
        @(posedge pcie_clk);
        cycle_cnt++;
    end
    $display("ERROR: run did not finish within %0d cycles", MAX_CYCLES);
    $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt + 1);
    $display("*** TEST FAILED ***");
    $finish;
end

initial begin
    int            seed_val;
    int            start_seen;
    logic [7:0]    page;
    logic [5:0]    qid;
    seed_val      = $urandom(SEED);
    pcie_reset_n  = 1'b0;
    mmio_wr       = '0;
    rx_meta       = '0;
    rx_meta_valid = 1'b0;
    qm_ready      = '0;
    repeat (8) @(posedge pcie_clk);
    #2;
    compare_value("reset qm_valid", 0, qm_valid);
    compare_value("reset rx_meta_ready", 0, rx_meta_ready);
    compare_value("reset sw_reset", 0, sw_reset);
    compare_value("reset disable_pcie", 0, disable_pcie);
    compare_value("reset eth_port_nb", 0, eth_port_nb);
    compare_value("reset ignored count", 0, rx_ignored_head_cnt);
    compare_value("reset head update count", 0, rx_pkt_head_upd_cnt);
    pcie_reset_n = 1'b1;
    next_cycle();

    // Control register writes.
    write_ctrl(0, 32'h1, 8'h0F);
    compare_value("disable_pcie set", 1, disable_pcie);
    write_ctrl(2, 32'h8000_0000, 8'h0F);
    compare_value("eth_port_nb set", 1, eth_port_nb);
    write_ctrl(0, 32'h0, 8'h07);
    write_ctrl(2, 32'h0, 8'hF0);
    compare_value("disable_pcie partial write", 1, disable_pcie);
    compare_value("eth_port_nb partial write", 1, eth_port_nb);
    write_ctrl(0, 32'h0, 8'h0F);
    write_ctrl(2, 32'h0, 8'h0F);
    compare_value("disable_pcie cleared", 0, disable_pcie);
    compare_value("eth_port_nb cleared", 0, eth_port_nb);

    ready_mode = 1;
    for (int i = 0; i < NB_PKTS; i++) begin
        repeat ($urandom % 3) next_cycle();
        send_pkt(6'($urandom), 16'($urandom));
    end
    wait_drain();

    ready_mode = 2;
    start_seen = head_seen;
    for (int i = 0; i < NB_HEADS; i++) begin
        qid = 6'($urandom);
        exp_head_q[expected_lane(qid)].push_back(expected_record(1'b1, qid, '0));
        write_head({2'b00, qid}, 8'hF0);
        if (i % 5 == 0) begin
            write_head(8'(64 + $urandom % 100), 8'hF0);
            write_head(8'($urandom % 64), 8'h70);
        end
        repeat (3) next_cycle();
    end
    wait_drain();
    compare_value("head records delivered", NB_HEADS, head_seen - start_seen);
    compare_value("head update count", NB_HEADS, rx_pkt_head_upd_cnt);
    compare_value("ignored count without overload", 0, rx_ignored_head_cnt);

    // Software reset follows register 0 bit 27 through two flops.
    write_ctrl(0, 32'h0800_0000, 8'h0F);
    compare_value("sw_reset after 1 cycle", 0, sw_reset);
    next_cycle();
    compare_value("sw_reset after 2 cycles", 0, sw_reset);
    next_cycle();
    compare_value("sw_reset after 3 cycles", 1, sw_reset);
    next_cycle();
    compare_value("head update count in sw_reset", 0, rx_pkt_head_upd_cnt);
    write_ctrl(0, 32'h0, 8'h0F);
    next_cycle();
    compare_value("sw_reset still set", 1, sw_reset);
    next_cycle();
    compare_value("sw_reset released", 0, sw_reset);

    ready_mode  = 0;
    check_heads = 1'b0;
    repeat (2) next_cycle();
    start_seen = head_seen;
    for (int i = 0; i < NB_BURST; i++) begin
        page = 8'(i % `MAX_NB_FLOWS);
        write_head(page, 8'hF0);
    end
    repeat (10) next_cycle();
    compare_value("records while lanes held", 0, head_seen - start_seen);
    ready_mode = 2;
    for (int n = 0; n < 200 && (head_seen - start_seen + rx_ignored_head_cnt) < NB_BURST; n++) begin
        next_cycle();
    end
    repeat (10) next_cycle();
    compare_value("overload delivered plus ignored", NB_BURST,
        head_seen - start_seen + rx_ignored_head_cnt);
    assert (rx_ignored_head_cnt > 0) else begin
        $display("ERROR: no head update was ignored during the overload burst");
        fail_cnt++;
    end

    $display("Summary: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if (mismatch_cnt == 0 && fail_cnt == 0) begin
        $display("*** TEST PASSED ***");
    end else begin
        $display("*** TEST FAILED ***");
    end
    $finish;
end

endmodule

//--- rx_meta_front.f
+incdir+.
rx_meta_pkg.sv
sync_fifo.sv
mmio_ctrl_decoder.sv
head_upd_tracker.sv
meta_merge_stage.sv
qm_dispatcher.sv
rx_meta_front.sv
tb_rx_meta_front.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_rx_meta_front
FILELIST  ?= rx_meta_front.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard *.svh)
BIN  := $(BUILD_DIR)/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -qF "*** TEST PASSED ***" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
